/* src/lsu_pkg.sv */
package lsu_pkg;

  // ----------------------------------------
  // Data path widths
  // ----------------------------------------
  localparam int ALEN_W = 64;
  localparam int ALEN_B = ALEN_W / 8;
  localparam int INST_W = 32;

  // RV major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // Access size, same as funct3[1:0]
  localparam logic [1:0] SIZE_B = 2'd0;
  localparam logic [1:0] SIZE_H = 2'd1;
  localparam logic [1:0] SIZE_W = 2'd2;
  localparam logic [1:0] SIZE_D = 2'd3;

  // ----------------------------------------
  // Instruction word, I-type or S-type view
  // ----------------------------------------
  typedef union packed {
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } ld;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } st;
  } lsu_inst_u;

endpackage

/* src/lsu_ctrl_decoder.sv */
`timescale 1ns/1ps

module lsu_ctrl_decoder (
  input  lsu_pkg::lsu_inst_u i_inst,
  output logic               o_is_load,
  output logic               o_is_store,
  output logic [1:0]         o_size,
  output logic               o_unsigned,
  output logic [11:0]        o_offset,
  output logic [4:0]         o_rd
);

  logic [6:0] w_opcode;

  assign w_opcode   = i_inst.ld.opcode;  // Same bits in both views
  assign o_is_load  = (w_opcode == lsu_pkg::OPC_LOAD);
  assign o_is_store = (w_opcode == lsu_pkg::OPC_STORE);

  assign o_size     = i_inst.ld.funct3[1:0];
  assign o_unsigned = i_inst.ld.funct3[2];  // LBU/LHU/LWU

  // S-type splits the immediate around rs2
  assign o_offset = o_is_store ? {i_inst.st.imm_hi, i_inst.st.imm_lo} :
                                 i_inst.ld.imm12;

  assign o_rd = i_inst.ld.rd;

endmodule

/* src/lsu_ex1_agen.sv */
`timescale 1ns/1ps

module lsu_ex1_agen #(
  parameter int TAG_W   = 6,
  parameter int PADDR_W = 40
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_ex0_valid,
  input  lsu_pkg::lsu_inst_u          i_ex0_inst,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex0_rs1_data,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex0_rs2_data,
  input  logic [TAG_W-1:0]            i_ex0_tag,

  output logic                        o_ex1_st_valid,
  output logic [PADDR_W-1:0]          o_ex1_st_paddr,
  output logic [lsu_pkg::ALEN_W-1:0]  o_ex1_st_data,
  output logic [1:0]                  o_ex1_st_size,

  output logic                        o_ex1_l1d_valid,
  output logic [PADDR_W-1:0]          o_ex1_l1d_paddr,

  output logic                        o_ex1_valid,
  output logic                        o_ex1_is_load,
  output logic [PADDR_W-1:0]          o_ex1_paddr,
  output logic [1:0]                  o_ex1_size,
  output logic                        o_ex1_unsigned,
  output logic [4:0]                  o_ex1_rd,
  output logic [TAG_W-1:0]            o_ex1_tag
);

  logic                       r_valid;
  lsu_pkg::lsu_inst_u         r_inst;
  logic [lsu_pkg::ALEN_W-1:0] r_rs1_data;
  logic [lsu_pkg::ALEN_W-1:0] r_rs2_data;
  logic [TAG_W-1:0]           r_tag;

  logic                       w_is_load;
  logic                       w_is_store;
  logic [11:0]                w_offset;
  logic [lsu_pkg::ALEN_W-1:0] w_addr_sum;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_ex0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_inst     <= i_ex0_inst;
    r_rs1_data <= i_ex0_rs1_data;
    r_rs2_data <= i_ex0_rs2_data;
    r_tag      <= i_ex0_tag;
  end

  lsu_ctrl_decoder u_decoder (
    .i_inst     (r_inst),
    .o_is_load  (w_is_load),
    .o_is_store (w_is_store),
    .o_size     (o_ex1_size),
    .o_unsigned (o_ex1_unsigned),
    .o_offset   (w_offset),
    .o_rd       (o_ex1_rd)
  );

  // VA == PA, no translation
  assign w_addr_sum  = r_rs1_data + {{(lsu_pkg::ALEN_W-12){w_offset[11]}}, w_offset};
  assign o_ex1_paddr = w_addr_sum[PADDR_W-1:0];

  // ----------------------------------------
  // Store queue update / L1D read
  // ----------------------------------------
  assign o_ex1_st_valid = r_valid & w_is_store;
  assign o_ex1_st_paddr = o_ex1_paddr;
  assign o_ex1_st_data  = r_rs2_data;
  assign o_ex1_st_size  = o_ex1_size;

  assign o_ex1_l1d_valid = r_valid & w_is_load;
  assign o_ex1_l1d_paddr = {o_ex1_paddr[PADDR_W-1:3], 3'b000};  // DW aligned

  assign o_ex1_valid   = r_valid;
  assign o_ex1_is_load = w_is_load;
  assign o_ex1_tag     = r_tag;

endmodule

/* src/lsu_byte_forward.sv */
`timescale 1ns/1ps

module lsu_byte_forward (
  input  logic [2:0]                 i_offset,
  input  logic [lsu_pkg::ALEN_B-1:0] i_need_mask,
  input  logic [lsu_pkg::ALEN_B-1:0] i_fwd_mask,
  input  logic [lsu_pkg::ALEN_W-1:0] i_fwd_data,
  input  logic [lsu_pkg::ALEN_W-1:0] i_l1d_data,
  output logic [lsu_pkg::ALEN_W-1:0] o_data,
  output logic                       o_covered
);

  logic [lsu_pkg::ALEN_W-1:0] w_merged;
  logic [lsu_pkg::ALEN_B-1:0] w_byte_ok;

  // ----------------------------------------
  // Per lane select, store data wins
  // ----------------------------------------
  for (genvar b = 0; b < lsu_pkg::ALEN_B; b++) begin : g_lane
    assign w_merged[b*8 +: 8] = i_fwd_mask[b] ? i_fwd_data[b*8 +: 8] :
                                                i_l1d_data[b*8 +: 8];
    assign w_byte_ok[b] = ~i_need_mask[b] | i_fwd_mask[b];
  end

  assign o_covered = &w_byte_ok;

  // Bring the accessed bytes down to lane 0
  assign o_data = w_merged >> {i_offset, 3'b000};

endmodule

/* src/lsu_ex2_load.sv */
`timescale 1ns/1ps

module lsu_ex2_load #(
  parameter int TAG_W   = 6,
  parameter int PADDR_W = 40
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_ex1_valid,
  input  logic                        i_ex1_is_load,
  input  logic [PADDR_W-1:0]          i_ex1_paddr,
  input  logic [1:0]                  i_ex1_size,
  input  logic                        i_ex1_unsigned,
  input  logic [4:0]                  i_ex1_rd,
  input  logic [TAG_W-1:0]            i_ex1_tag,

  input  logic                        i_ex2_l1d_hit,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex2_l1d_data,
  input  logic [lsu_pkg::ALEN_B-1:0]  i_ex2_fwd_mask,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex2_fwd_data,

  output logic                        o_ex2_fwd_valid,
  output logic [PADDR_W-1:0]          o_ex2_fwd_paddr,
  output logic [lsu_pkg::ALEN_B-1:0]  o_ex2_fwd_mask,

  output logic                        o_ex2_replay_valid,
  output logic [TAG_W-1:0]            o_ex2_replay_tag,

  output logic                        o_ex2_valid,
  output logic                        o_ex2_is_load,
  output logic [1:0]                  o_ex2_size,
  output logic                        o_ex2_unsigned,
  output logic [4:0]                  o_ex2_rd,
  output logic [TAG_W-1:0]            o_ex2_tag,
  output logic [lsu_pkg::ALEN_W-1:0]  o_ex2_data
);

  logic                       r_valid;
  logic                       r_is_load;
  logic [PADDR_W-1:0]         r_paddr;
  logic [1:0]                 r_size;
  logic                       r_unsigned;
  logic [4:0]                 r_rd;
  logic [TAG_W-1:0]           r_tag;

  logic [lsu_pkg::ALEN_B-1:0] w_size_mask;
  logic                       w_covered;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_is_load  <= i_ex1_is_load;
    r_paddr    <= i_ex1_paddr;
    r_size     <= i_ex1_size;
    r_unsigned <= i_ex1_unsigned;
    r_rd       <= i_ex1_rd;
    r_tag      <= i_ex1_tag;
  end

  always_comb begin
    case (r_size)
      lsu_pkg::SIZE_B: w_size_mask = 8'h01;
      lsu_pkg::SIZE_H: w_size_mask = 8'h03;
      lsu_pkg::SIZE_W: w_size_mask = 8'h0f;
      default:         w_size_mask = 8'hff;
    endcase
  end

  // ----------------------------------------
  // STQ forwarding request
  // ----------------------------------------
  assign o_ex2_fwd_valid = r_valid & r_is_load;
  assign o_ex2_fwd_paddr = r_paddr;
  assign o_ex2_fwd_mask  = w_size_mask << r_paddr[2:0];  // aligned, never wraps

  lsu_byte_forward u_byte_forward (
    .i_offset    (r_paddr[2:0]),
    .i_need_mask (o_ex2_fwd_mask),
    .i_fwd_mask  (i_ex2_fwd_mask),
    .i_fwd_data  (i_ex2_fwd_data),
    .i_l1d_data  (i_ex2_l1d_data),
    .o_data      (o_ex2_data),
    .o_covered   (w_covered)
  );

  // Miss is harmless when the STQ supplies every byte
  assign o_ex2_replay_valid = r_valid & r_is_load & ~w_covered & ~i_ex2_l1d_hit;
  assign o_ex2_replay_tag   = r_tag;

  assign o_ex2_valid    = r_valid & ~o_ex2_replay_valid;
  assign o_ex2_is_load  = r_is_load;
  assign o_ex2_size     = r_size;
  assign o_ex2_unsigned = r_unsigned;
  assign o_ex2_rd       = r_rd;
  assign o_ex2_tag      = r_tag;

endmodule

/* src/lsu_load_extend.sv */
`timescale 1ns/1ps

module lsu_load_extend (
  input  logic [lsu_pkg::ALEN_W-1:0] i_data,
  input  logic [1:0]                 i_size,
  input  logic                       i_unsigned,
  output logic [lsu_pkg::ALEN_W-1:0] o_data
);

  localparam int W = lsu_pkg::ALEN_W;

  logic w_msb;

  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_B: w_msb = i_data[7];
      lsu_pkg::SIZE_H: w_msb = i_data[15];
      lsu_pkg::SIZE_W: w_msb = i_data[31];
      default:         w_msb = i_data[W-1];
    endcase
  end

  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_B: o_data = {{(W-8){w_msb & ~i_unsigned}}, i_data[7:0]};
      lsu_pkg::SIZE_H: o_data = {{(W-16){w_msb & ~i_unsigned}}, i_data[15:0]};
      lsu_pkg::SIZE_W: o_data = {{(W-32){w_msb & ~i_unsigned}}, i_data[31:0]};
      default:         o_data = i_data;  // LD, nothing to fill
    endcase
  end

endmodule

/* src/lsu_ex3_writeback.sv */
`timescale 1ns/1ps

module lsu_ex3_writeback #(
  parameter int TAG_W = 6
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  logic                        i_ex2_valid,
  input  logic                        i_ex2_is_load,
  input  logic [1:0]                  i_ex2_size,
  input  logic                        i_ex2_unsigned,
  input  logic [4:0]                  i_ex2_rd,
  input  logic [TAG_W-1:0]            i_ex2_tag,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex2_data,

  output logic                        o_ex3_done_valid,
  output logic [TAG_W-1:0]            o_ex3_done_tag,
  output logic                        o_ex3_wr_valid,
  output logic [4:0]                  o_ex3_wr_rd,
  output logic [lsu_pkg::ALEN_W-1:0]  o_ex3_wr_data
);

  logic [lsu_pkg::ALEN_W-1:0] w_ext_data;

  lsu_load_extend u_load_extend (
    .i_data     (i_ex2_data),
    .i_size     (i_ex2_size),
    .i_unsigned (i_ex2_unsigned),
    .o_data     (w_ext_data)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex3_done_valid <= 1'b0;
      o_ex3_wr_valid   <= 1'b0;
    end else begin
      o_ex3_done_valid <= i_ex2_valid;
      o_ex3_wr_valid   <= i_ex2_valid & i_ex2_is_load & (i_ex2_rd != 5'd0);  // x0 dropped
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex3_done_tag <= i_ex2_tag;
    o_ex3_wr_rd    <= i_ex2_rd;
    o_ex3_wr_data  <= w_ext_data;
  end

endmodule

/* src/lsu_pipe.sv */
`timescale 1ns/1ps

module lsu_pipe #(
  parameter int TAG_W   = 6,
  parameter int PADDR_W = 40
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  // Issue
  input  logic                        i_ex0_valid,
  input  logic [lsu_pkg::INST_W-1:0]  i_ex0_inst,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex0_rs1_data,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex0_rs2_data,
  input  logic [TAG_W-1:0]            i_ex0_tag,

  // STQ update
  output logic                        o_ex1_st_valid,
  output logic [PADDR_W-1:0]          o_ex1_st_paddr,
  output logic [lsu_pkg::ALEN_W-1:0]  o_ex1_st_data,
  output logic [1:0]                  o_ex1_st_size,

  // L1D
  output logic                        o_ex1_l1d_valid,
  output logic [PADDR_W-1:0]          o_ex1_l1d_paddr,
  input  logic                        i_ex2_l1d_hit,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex2_l1d_data,

  // STQ forwarding
  output logic                        o_ex2_fwd_valid,
  output logic [PADDR_W-1:0]          o_ex2_fwd_paddr,
  output logic [lsu_pkg::ALEN_B-1:0]  o_ex2_fwd_mask,
  input  logic [lsu_pkg::ALEN_B-1:0]  i_ex2_fwd_mask,
  input  logic [lsu_pkg::ALEN_W-1:0]  i_ex2_fwd_data,

  output logic                        o_ex2_replay_valid,
  output logic [TAG_W-1:0]            o_ex2_replay_tag,

  // Completion
  output logic                        o_ex3_done_valid,
  output logic [TAG_W-1:0]            o_ex3_done_tag,
  output logic                        o_ex3_wr_valid,
  output logic [4:0]                  o_ex3_wr_rd,
  output logic [lsu_pkg::ALEN_W-1:0]  o_ex3_wr_data
);

  logic                       w_ex1_valid;
  logic                       w_ex1_is_load;
  logic [PADDR_W-1:0]         w_ex1_paddr;
  logic [1:0]                 w_ex1_size;
  logic                       w_ex1_unsigned;
  logic [4:0]                 w_ex1_rd;
  logic [TAG_W-1:0]           w_ex1_tag;

  logic                       w_ex2_valid;
  logic                       w_ex2_is_load;
  logic [1:0]                 w_ex2_size;
  logic                       w_ex2_unsigned;
  logic [4:0]                 w_ex2_rd;
  logic [TAG_W-1:0]           w_ex2_tag;
  logic [lsu_pkg::ALEN_W-1:0] w_ex2_data;

  lsu_ex1_agen #(.TAG_W(TAG_W), .PADDR_W(PADDR_W)) u_ex1 (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_ex0_valid     (i_ex0_valid),
    .i_ex0_inst      (i_ex0_inst),
    .i_ex0_rs1_data  (i_ex0_rs1_data),
    .i_ex0_rs2_data  (i_ex0_rs2_data),
    .i_ex0_tag       (i_ex0_tag),
    .o_ex1_st_valid  (o_ex1_st_valid),
    .o_ex1_st_paddr  (o_ex1_st_paddr),
    .o_ex1_st_data   (o_ex1_st_data),
    .o_ex1_st_size   (o_ex1_st_size),
    .o_ex1_l1d_valid (o_ex1_l1d_valid),
    .o_ex1_l1d_paddr (o_ex1_l1d_paddr),
    .o_ex1_valid     (w_ex1_valid),
    .o_ex1_is_load   (w_ex1_is_load),
    .o_ex1_paddr     (w_ex1_paddr),
    .o_ex1_size      (w_ex1_size),
    .o_ex1_unsigned  (w_ex1_unsigned),
    .o_ex1_rd        (w_ex1_rd),
    .o_ex1_tag       (w_ex1_tag)
  );

  lsu_ex2_load #(.TAG_W(TAG_W), .PADDR_W(PADDR_W)) u_ex2 (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_ex1_valid        (w_ex1_valid),
    .i_ex1_is_load      (w_ex1_is_load),
    .i_ex1_paddr        (w_ex1_paddr),
    .i_ex1_size         (w_ex1_size),
    .i_ex1_unsigned     (w_ex1_unsigned),
    .i_ex1_rd           (w_ex1_rd),
    .i_ex1_tag          (w_ex1_tag),
    .i_ex2_l1d_hit      (i_ex2_l1d_hit),
    .i_ex2_l1d_data     (i_ex2_l1d_data),
    .i_ex2_fwd_mask     (i_ex2_fwd_mask),
    .i_ex2_fwd_data     (i_ex2_fwd_data),
    .o_ex2_fwd_valid    (o_ex2_fwd_valid),
    .o_ex2_fwd_paddr    (o_ex2_fwd_paddr),
    .o_ex2_fwd_mask     (o_ex2_fwd_mask),
    .o_ex2_replay_valid (o_ex2_replay_valid),
    .o_ex2_replay_tag   (o_ex2_replay_tag),
    .o_ex2_valid        (w_ex2_valid),
    .o_ex2_is_load      (w_ex2_is_load),
    .o_ex2_size         (w_ex2_size),
    .o_ex2_unsigned     (w_ex2_unsigned),
    .o_ex2_rd           (w_ex2_rd),
    .o_ex2_tag          (w_ex2_tag),
    .o_ex2_data         (w_ex2_data)
  );

  lsu_ex3_writeback #(.TAG_W(TAG_W)) u_ex3 (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_ex2_valid      (w_ex2_valid),
    .i_ex2_is_load    (w_ex2_is_load),
    .i_ex2_size       (w_ex2_size),
    .i_ex2_unsigned   (w_ex2_unsigned),
    .i_ex2_rd         (w_ex2_rd),
    .i_ex2_tag        (w_ex2_tag),
    .i_ex2_data       (w_ex2_data),
    .o_ex3_done_valid (o_ex3_done_valid),
    .o_ex3_done_tag   (o_ex3_done_tag),
    .o_ex3_wr_valid   (o_ex3_wr_valid),
    .o_ex3_wr_rd      (o_ex3_wr_rd),
    .o_ex3_wr_data    (o_ex3_wr_data)
  );

endmodule

/* test/tb_lsu_pipe.sv */
`timescale 1ns/1ps

module tb_lsu_pipe;

  localparam int TAG_W     = 6;
  localparam int PADDR_W   = 40;
  localparam int ALEN_W    = lsu_pkg::ALEN_W;
  localparam int ALEN_B    = lsu_pkg::ALEN_B;
  localparam int NUM_TESTS = 19;
  localparam int SEED      = 32'h1d9e94eb;

  localparam logic [6:0] LD = lsu_pkg::OPC_LOAD;
  localparam logic [6:0] ST = lsu_pkg::OPC_STORE;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_ex0_valid;
  logic [31:0]         i_ex0_inst;
  logic [ALEN_W-1:0]   i_ex0_rs1_data;
  logic [ALEN_W-1:0]   i_ex0_rs2_data;
  logic [TAG_W-1:0]    i_ex0_tag;
  logic                i_ex2_l1d_hit;
  logic [ALEN_W-1:0]   i_ex2_l1d_data;
  logic [ALEN_B-1:0]   i_ex2_fwd_mask;
  logic [ALEN_W-1:0]   i_ex2_fwd_data;

  logic                o_ex1_st_valid;
  logic [PADDR_W-1:0]  o_ex1_st_paddr;
  logic [ALEN_W-1:0]   o_ex1_st_data;
  logic [1:0]          o_ex1_st_size;
  logic                o_ex1_l1d_valid;
  logic [PADDR_W-1:0]  o_ex1_l1d_paddr;
  logic                o_ex2_fwd_valid;
  logic [PADDR_W-1:0]  o_ex2_fwd_paddr;
  logic [ALEN_B-1:0]   o_ex2_fwd_mask;
  logic                o_ex2_replay_valid;
  logic [TAG_W-1:0]    o_ex2_replay_tag;
  logic                o_ex3_done_valid;
  logic [TAG_W-1:0]    o_ex3_done_tag;
  logic                o_ex3_wr_valid;
  logic [4:0]          o_ex3_wr_rd;
  logic [ALEN_W-1:0]   o_ex3_wr_data;

  // ----------------------------------------
  // Stimulus table, exp is {done, replay, wr}
  // ----------------------------------------
  string               tab_name  [NUM_TESTS];
  logic [6:0]          tab_opc   [NUM_TESTS];
  logic [2:0]          tab_f3    [NUM_TESTS];
  logic [4:0]          tab_rd    [NUM_TESTS];
  logic [11:0]         tab_imm   [NUM_TESTS];
  logic [ALEN_W-1:0]   tab_rs1   [NUM_TESTS];
  logic [TAG_W-1:0]    tab_tag   [NUM_TESTS];
  logic                tab_hit   [NUM_TESTS];
  logic [ALEN_B-1:0]   tab_fmask [NUM_TESTS];
  logic [2:0]          tab_exp   [NUM_TESTS];
  logic [ALEN_W-1:0]   rnd_rs2   [NUM_TESTS];
  logic [ALEN_W-1:0]   rnd_l1d   [NUM_TESTS];
  logic [ALEN_W-1:0]   rnd_fwd   [NUM_TESTS];
  int                  test_err  [NUM_TESTS];
  int                  row_count;
  int                  total_err;

  lsu_pipe #(.TAG_W(TAG_W), .PADDR_W(PADDR_W)) uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    #((NUM_TESTS + 10) * 10 * 2);
    $display("Watchdog expired before the stimulus table was finished");
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic add_row(input string name, input logic [6:0] opc, input logic [2:0] f3,
                         input logic [4:0] rd, input logic [11:0] imm,
                         input logic [ALEN_W-1:0] rs1, input logic [TAG_W-1:0] tag,
                         input logic hit, input logic [ALEN_B-1:0] fmask,
                         input logic [2:0] exp);
    tab_name[row_count]  = name;
    tab_opc[row_count]   = opc;
    tab_f3[row_count]    = f3;
    tab_rd[row_count]    = rd;
    tab_imm[row_count]   = imm;
    tab_rs1[row_count]   = rs1;
    tab_tag[row_count]   = tag;
    tab_hit[row_count]   = hit;
    tab_fmask[row_count] = fmask;
    tab_exp[row_count]   = exp;
    rnd_rs2[row_count]   = {$urandom, $urandom};
    rnd_l1d[row_count]   = {$urandom, $urandom};
    rnd_fwd[row_count]   = {$urandom, $urandom};
    test_err[row_count]  = 0;
    row_count++;
  endtask

  task automatic fill_table();
    add_row("sd store",        ST, 3'd3, 5'd0,  12'h010, 64'h1000, 6'd1,  0, 8'h00, 3'b100);
    add_row("sw store neg imm", ST, 3'd2, 5'd0, 12'hffc, 64'hffff_ff00_0000_2008, 6'd2, 0,
            8'h00, 3'b100);
    add_row("lb hit",          LD, 3'd0, 5'd5,  12'h003, 64'h3000, 6'd3,  1, 8'h00, 3'b101);
    add_row("lbu hit",         LD, 3'd4, 5'd6,  12'h005, 64'h3000, 6'd4,  1, 8'h00, 3'b101);
    add_row("lh hit",          LD, 3'd1, 5'd7,  12'h006, 64'h3000, 6'd5,  1, 8'h00, 3'b101);
    add_row("lhu hit",         LD, 3'd5, 5'd8,  12'h002, 64'h3000, 6'd6,  1, 8'h00, 3'b101);
    add_row("lw hit",          LD, 3'd2, 5'd9,  12'h004, 64'h3000, 6'd7,  1, 8'h00, 3'b101);
    add_row("lwu hit",         LD, 3'd6, 5'd10, 12'h000, 64'h3000, 6'd8,  1, 8'h00, 3'b101);
    add_row("ld hit",          LD, 3'd3, 5'd11, 12'h008, 64'h3000, 6'd9,  1, 8'h00, 3'b101);
    add_row("lw partial fwd",  LD, 3'd2, 5'd12, 12'h004, 64'h3000, 6'd10, 1, 8'h30, 3'b101);
    add_row("lh fwd low lane", LD, 3'd1, 5'd13, 12'hffa, 64'h3008, 6'd11, 1, 8'h04, 3'b101);
    add_row("lw miss partial", LD, 3'd2, 5'd15, 12'h004, 64'h3000, 6'd12, 0, 8'h30, 3'b010);
    add_row("lb miss",         LD, 3'd0, 5'd16, 12'h001, 64'h3000, 6'd13, 0, 8'h00, 3'b010);
    add_row("lhu miss all fwd", LD, 3'd5, 5'd17, 12'h006, 64'h3000, 6'd14, 0, 8'hc0, 3'b101);
    add_row("ld to x0",        LD, 3'd3, 5'd0,  12'h010, 64'h3000, 6'd15, 1, 8'h00, 3'b100);
    add_row("sh store b2b",    ST, 3'd1, 5'd0,  12'h002, 64'h5000, 6'd16, 0, 8'h00, 3'b100);
    add_row("lbu fwd b2b",     LD, 3'd4, 5'd18, 12'h007, 64'h5000, 6'd17, 1, 8'h80, 3'b101);
    add_row("sb store b2b",    ST, 3'd0, 5'd0,  12'h7ff, 64'h5000, 6'd18, 0, 8'h00, 3'b100);
    add_row("lw miss b2b",     LD, 3'd2, 5'd19, 12'h008, 64'h5000, 6'd19, 0, 8'h00, 3'b010);
  endtask

  function automatic logic [31:0] make_inst(input int e);
    if (tab_opc[e] == ST)
      return {tab_imm[e][11:5], 5'd2, 5'd1, tab_f3[e], tab_imm[e][4:0], tab_opc[e]};
    return {tab_imm[e], 5'd1, tab_f3[e], tab_rd[e], tab_opc[e]};
  endfunction

  function automatic logic [PADDR_W-1:0] expected_addr(input int e);
    logic [ALEN_W-1:0] sum;
    sum = tab_rs1[e] + {{(ALEN_W-12){tab_imm[e][11]}}, tab_imm[e]};
    return sum[PADDR_W-1:0];
  endfunction

  // Lane merge, shift to byte 0, then fill above the access size
  function automatic logic [ALEN_W-1:0] expected_load(input int e);
    logic [PADDR_W-1:0] addr;
    logic [ALEN_W-1:0]  merged;
    int                 nbytes;
    addr = expected_addr(e);
    for (int b = 0; b < ALEN_B; b++)
      merged[b*8 +: 8] = tab_fmask[e][b] ? rnd_fwd[e][b*8 +: 8] : rnd_l1d[e][b*8 +: 8];
    merged = merged >> (8 * addr[2:0]);
    nbytes = 1 << tab_f3[e][1:0];
    for (int b = nbytes; b < ALEN_B; b++)
      merged[b*8 +: 8] = (tab_f3[e][2] || !merged[nbytes*8-1]) ? 8'h00 : 8'hff;
    return merged;
  endfunction

  task automatic log_failure(input int idx, input string name,
                             input logic [ALEN_W-1:0] got, input logic [ALEN_W-1:0] exp);
    $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    total_err++;
    if (idx >= 0 && idx < NUM_TESTS) test_err[idx]++;
  endtask

  task automatic check_bit(input int idx, input string name, input logic got, input logic exp);
    if (got !== exp) log_failure(idx, name, ALEN_W'(got), ALEN_W'(exp));
  endtask

  task automatic check_tag(input int idx, input string name,
                           input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp);
    if (got !== exp) log_failure(idx, name, ALEN_W'(got), ALEN_W'(exp));
  endtask

  task automatic check_addr(input int idx, input string name,
                            input logic [PADDR_W-1:0] got, input logic [PADDR_W-1:0] exp);
    if (got !== exp) log_failure(idx, name, ALEN_W'(got), ALEN_W'(exp));
  endtask

  task automatic check_data(input int idx, input string name,
                            input logic [ALEN_W-1:0] got, input logic [ALEN_W-1:0] exp);
    if (got !== exp) log_failure(idx, name, got, exp);
  endtask

  task automatic check_mask(input int idx, input string name,
                            input logic [ALEN_B-1:0] got, input logic [ALEN_B-1:0] exp);
    if (got !== exp) log_failure(idx, name, ALEN_W'(got), ALEN_W'(exp));
  endtask

  task automatic check_size(input int idx, input string name,
                            input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) log_failure(idx, name, ALEN_W'(got), ALEN_W'(exp));
  endtask

  task automatic check_rd(input int idx, input string name,
                          input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) log_failure(idx, name, ALEN_W'(got), ALEN_W'(exp));
  endtask

  // ----------------------------------------
  // Drivers, out of range means idle
  // ----------------------------------------
  task automatic drive_issue(input int e);
    logic live;
    live = (e >= 0) && (e < NUM_TESTS);
    i_ex0_valid    = live;
    i_ex0_inst     = live ? make_inst(e) : '0;
    i_ex0_rs1_data = live ? tab_rs1[e] : '0;
    i_ex0_rs2_data = live ? rnd_rs2[e] : '0;
    i_ex0_tag      = live ? tab_tag[e] : '0;
  endtask

  task automatic drive_cache_answer(input int e);
    logic live;
    live = (e >= 0) && (e < NUM_TESTS);
    i_ex2_l1d_hit  = live ? tab_hit[e] : 1'b0;
    i_ex2_l1d_data = live ? rnd_l1d[e] : '0;
    i_ex2_fwd_mask = live ? tab_fmask[e] : '0;
    i_ex2_fwd_data = live ? rnd_fwd[e] : '0;
  endtask

  task automatic verify_issue_stage(input int e);
    logic               is_st;
    logic               is_ld;
    logic [PADDR_W-1:0] addr;
    is_st = (e >= 0) && (e < NUM_TESTS) && (tab_opc[e] == ST);
    is_ld = (e >= 0) && (e < NUM_TESTS) && (tab_opc[e] == LD);
    check_bit(e, "o_ex1_st_valid", o_ex1_st_valid, is_st);
    check_bit(e, "o_ex1_l1d_valid", o_ex1_l1d_valid, is_ld);
    if (is_st || is_ld) addr = expected_addr(e);
    if (is_st) begin
      check_addr(e, "o_ex1_st_paddr", o_ex1_st_paddr, addr);
      check_data(e, "o_ex1_st_data", o_ex1_st_data, rnd_rs2[e]);
      check_size(e, "o_ex1_st_size", o_ex1_st_size, tab_f3[e][1:0]);
    end
    if (is_ld) check_addr(e, "o_ex1_l1d_paddr", o_ex1_l1d_paddr, {addr[PADDR_W-1:3], 3'b000});
  endtask

  task automatic verify_load_stage(input int e);
    logic               is_ld;
    logic               replay;
    logic [PADDR_W-1:0] addr;
    logic [15:0]        need;
    is_ld  = (e >= 0) && (e < NUM_TESTS) && (tab_opc[e] == LD);
    replay = (e >= 0) && (e < NUM_TESTS) && tab_exp[e][1];
    check_bit(e, "o_ex2_fwd_valid", o_ex2_fwd_valid, is_ld);
    check_bit(e, "o_ex2_replay_valid", o_ex2_replay_valid, replay);
    if (is_ld) begin
      addr = expected_addr(e);
      need = ((16'd1 << (1 << tab_f3[e][1:0])) - 16'd1) << addr[2:0];
      check_addr(e, "o_ex2_fwd_paddr", o_ex2_fwd_paddr, addr);
      check_mask(e, "o_ex2_fwd_mask", o_ex2_fwd_mask, need[ALEN_B-1:0]);
    end
    if (replay) check_tag(e, "o_ex2_replay_tag", o_ex2_replay_tag, tab_tag[e]);
  endtask

  task automatic verify_writeback(input int e);
    logic done;
    logic wr;
    done = (e >= 0) && (e < NUM_TESTS) && tab_exp[e][2];
    wr   = (e >= 0) && (e < NUM_TESTS) && tab_exp[e][0];
    check_bit(e, "o_ex3_done_valid", o_ex3_done_valid, done);
    check_bit(e, "o_ex3_wr_valid", o_ex3_wr_valid, wr);
    if (done) check_tag(e, "o_ex3_done_tag", o_ex3_done_tag, tab_tag[e]);
    if (wr) begin
      check_rd(e, "o_ex3_wr_rd", o_ex3_wr_rd, tab_rd[e]);
      check_data(e, "o_ex3_wr_data", o_ex3_wr_data, expected_load(e));
    end
  endtask

  task automatic report_test(input int e);
    if (e >= 0 && e < NUM_TESTS)
      $display("test %0d %-18s %s", e, tab_name[e], (test_err[e] == 0) ? "pass" : "FAIL");
  endtask

  initial begin
    int passed;
    void'($urandom(SEED));
    i_reset_n = 1'b0;
    row_count = 0;
    total_err = 0;
    drive_issue(-1);
    drive_cache_answer(-1);
    fill_table();

    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // Entry j issues now, j-1 is in EX1, j-2 in EX2, j-3 in EX3
    for (int j = 0; j < NUM_TESTS + 3; j++) begin
      @(negedge i_clk);
      drive_issue(j);
      drive_cache_answer(j - 2);
      #1;
      verify_issue_stage(j - 1);
      verify_load_stage(j - 2);
      verify_writeback(j - 3);
      report_test(j - 3);
    end

    passed = 0;
    foreach (test_err[e]) if (test_err[e] == 0) passed++;
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, passed, NUM_TESTS - passed, total_err);
    if (total_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* lsu_pipe.f */
src/lsu_pkg.sv
src/lsu_ctrl_decoder.sv
src/lsu_ex1_agen.sv
src/lsu_byte_forward.sv
src/lsu_ex2_load.sv
src/lsu_load_extend.sv
src/lsu_ex3_writeback.sv
src/lsu_pipe.sv
test/tb_lsu_pipe.sv

/* Bender.yml */
package:
  name: lsu_pipe

sources:
  - src/lsu_pkg.sv
  - src/lsu_ctrl_decoder.sv
  - src/lsu_ex1_agen.sv
  - src/lsu_byte_forward.sv
  - src/lsu_ex2_load.sv
  - src/lsu_load_extend.sv
  - src/lsu_ex3_writeback.sv
  - src/lsu_pipe.sv
  - target: test
    files:
      - test/tb_lsu_pipe.sv
